// File: frame_top.f
logic/frame_pkg.sv
logic/frame_regs.sv
logic/frame_reset.sv
logic/frame_rom_ctrl.sv
logic/frame_sd_dac.sv
logic/frame_top.sv
tests/frame_tb.sv

// File: Bender.yml
package:
  name: frame_top

sources:
  - logic/frame_pkg.sv
  - logic/frame_regs.sv
  - logic/frame_reset.sv
  - logic/frame_rom_ctrl.sv
  - logic/frame_sd_dac.sv
  - logic/frame_top.sv
  - target: test
    files:
      - tests/frame_tb.sv

// File: tests/frame_tb.sv
// Directed checks against the fixed register map; assumes RST_HOLD of 16 and inverted game inputs
`timescale 1ns/1ps

module frame_tb;

    localparam int TIMEOUT = 50;      // Cycles allowed per wait
    localparam int DL_BASE = 'h100;   // Word aligned byte address
    localparam int DL_LEN  = 64;

    logic        clk_sys;
    logic        rst;
    logic        rst_req;
    logic [15:0] snd;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [2:0]  wb_adr;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;
    logic        rom_req;
    logic [9:0]  rom_addr;
    logic        rom_ack;
    logic [31:0] rom_data;
    logic        rom_data_rdy;
    logic        downloading;
    logic        game_rst;
    logic [9:0]  game_joystick1;
    logic [9:0]  game_joystick2;
    logic [1:0]  game_coin;
    logic [1:0]  game_start;
    logic        game_pause;
    logic        game_service;
    logic [3:0]  gfx_en;
    logic        AUDIO_L;
    logic        AUDIO_R;

    logic [15:0] lfsr;
    logic [7:0]  dl_bytes [DL_LEN];  // Bytes streamed during the download test

    frame_top uut (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .rst_req        ( rst_req        ),
        .snd            ( snd            ),
        .wb_cyc         ( wb_cyc         ),
        .wb_stb         ( wb_stb         ),
        .wb_we          ( wb_we          ),
        .wb_adr         ( wb_adr         ),
        .wb_dat_w       ( wb_dat_w       ),
        .wb_dat_r       ( wb_dat_r       ),
        .wb_ack         ( wb_ack         ),
        .rom_req        ( rom_req        ),
        .rom_addr       ( rom_addr       ),
        .rom_ack        ( rom_ack        ),
        .rom_data       ( rom_data       ),
        .rom_data_rdy   ( rom_data_rdy   ),
        .downloading    ( downloading    ),
        .game_rst       ( game_rst       ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_pause     ( game_pause     ),
        .game_service   ( game_service   ),
        .gfx_en         ( gfx_en         ),
        .AUDIO_L        ( AUDIO_L        ),
        .AUDIO_R        ( AUDIO_R        )
    );

    initial begin
        clk_sys = 1'b0;
        forever #5 clk_sys = ~clk_sys;
    end

    task automatic abort_run();
        $display("Done: errors found");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic expect_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("Fail %s: got %h, expected %h", name, got, exp);
            abort_run();
        end
    endtask

    // Inputs change 1 ns past the edge, outputs are sampled there too
    task automatic next_cycle();
        @(posedge clk_sys);
        #1;
    endtask

    // Galois form, taps for x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    task automatic random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr = lfsr_step(lfsr);
            b = {b[6:0], lfsr[0]};
        end
    endtask

    task automatic wb_cycle(input logic we, input logic [2:0] adr, input logic [31:0] dat_w,
                            output logic [31:0] dat_r);
        int cnt;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = dat_w;
        cnt = 0;
        next_cycle();
        while (wb_ack !== 1'b1) begin
            if (cnt == TIMEOUT) begin
                $display("Timeout waiting for wb_ack at address %0d", adr);
                abort_run();
            end
            next_cycle();
            cnt++;
        end
        expect_eq("wb_ack latency", cnt, 0);
        dat_r = wb_dat_r;
        next_cycle();
        expect_eq("wb_ack", wb_ack, 0);  // Strobe still high through the ack cycle
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] dat);
        logic [31:0] unused;
        wb_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] dat);
        wb_cycle(1'b0, adr, 32'h0, dat);
    endtask

    // Waits for the ack, then expects data one cycle later
    task automatic rom_finish(output logic [31:0] data);
        int cnt;
        cnt = 0;
        while (rom_ack !== 1'b1) begin
            if (cnt == TIMEOUT) begin
                $display("Timeout waiting for rom_ack");
                abort_run();
            end
            next_cycle();
            cnt++;
        end
        rom_req = 1'b0;
        next_cycle();
        expect_eq("rom_data_rdy", rom_data_rdy, 1);
        expect_eq("rom_ack", rom_ack, 0);
        data = rom_data;
    endtask

    task automatic rom_read(input logic [9:0] addr, output logic [31:0] data);
        rom_req  = 1'b1;
        rom_addr = addr;
        rom_finish(data);
    endtask

    task automatic expect_hold();
        for (int i = 0; i < frame_pkg::RST_HOLD; i++) begin
            expect_eq("game_rst", game_rst, 1);
            next_cycle();
        end
        expect_eq("game_rst", game_rst, 0);
    endtask

    task automatic reg_access();
        logic [31:0] rd;
        wb_write(frame_pkg::REG_STATUS, 32'h5A3C_0F00);  // Flip clear
        wb_write(frame_pkg::REG_JOY1, 32'h0000_02A5);
        wb_write(frame_pkg::REG_JOY2, 32'hFFFF_F15A);    // Only 10 bits kept
        wb_read(frame_pkg::REG_STATUS, rd);
        expect_eq("wb_dat_r status", rd, 32'h5A3C_0F00);
        wb_read(frame_pkg::REG_JOY1, rd);
        expect_eq("wb_dat_r joy1", rd, 32'h0000_02A5);
        wb_read(frame_pkg::REG_JOY2, rd);
        expect_eq("wb_dat_r joy2", rd, 32'h0000_015A);
        wb_read(frame_pkg::REG_DL_DATA, rd);
        expect_eq("wb_dat_r dl_data", rd, 0);
        wb_read(3'd6, rd);
        expect_eq("wb_dat_r unmapped", rd, 0);
        wb_read(3'd7, rd);
        expect_eq("wb_dat_r unmapped", rd, 0);
    endtask

    task automatic input_decode();
        frame_pkg::frame_status_u st;
        logic [9:0] j1;
        logic [9:0] j2;
        logic [9:0] exp_j;
        logic [1:0] exp_2;
        st.raw = '0;
        st.fields.pause  = 1'b1;
        st.fields.gfx_en = 4'h9;
        wb_write(frame_pkg::REG_STATUS, st.raw);
        expect_eq("game_pause", game_pause, 1);
        expect_eq("game_service", game_service, 0);
        expect_eq("gfx_en", gfx_en, 4'h9);
        st.fields.pause   = 1'b0;
        st.fields.service = 1'b1;
        st.fields.gfx_en  = 4'h6;
        wb_write(frame_pkg::REG_STATUS, st.raw);
        expect_eq("game_pause", game_pause, 0);
        expect_eq("game_service", game_service, 1);
        expect_eq("gfx_en", gfx_en, 4'h6);
        j1 = 10'h1A5;  // Coin pressed
        j2 = 10'h2C3;  // Start pressed
        wb_write(frame_pkg::REG_JOY1, {22'h0, j1});
        wb_write(frame_pkg::REG_JOY2, {22'h0, j2});
        exp_j = ~j1;
        expect_eq("game_joystick1", game_joystick1, exp_j);
        exp_j = ~j2;
        expect_eq("game_joystick2", game_joystick2, exp_j);
        exp_2 = ~{j2[8], j1[8]};
        expect_eq("game_coin", game_coin, exp_2);
        exp_2 = ~{j2[9], j1[9]};
        expect_eq("game_start", game_start, exp_2);
    endtask

    task automatic download_readback();
        logic [31:0] rd;
        logic [31:0] word;
        logic [31:0] exp;
        wb_write(frame_pkg::REG_DL_CTRL, 32'h1);
        expect_eq("downloading", downloading, 1);
        wb_write(frame_pkg::REG_DL_ADDR, DL_BASE);
        for (int i = 0; i < DL_LEN; i++) begin
            random_byte(dl_bytes[i]);
            wb_write(frame_pkg::REG_DL_DATA, {24'hC3C3C3, dl_bytes[i]});
            expect_eq("game_rst", game_rst, 1);  // Held for the whole download
        end
        wb_read(frame_pkg::REG_DL_ADDR, rd);
        expect_eq("dl_addr", rd, DL_BASE + DL_LEN);
        wb_write(frame_pkg::REG_DL_CTRL, 32'h0);
        for (int w = 0; w < DL_LEN / 4; w++) begin
            exp = {dl_bytes[4*w+3], dl_bytes[4*w+2], dl_bytes[4*w+1], dl_bytes[4*w]};
            rom_read(DL_BASE / 4 + w, word);
            expect_eq("rom_data", word, exp);
        end
    endtask

    task automatic read_while_loading();
        logic [31:0] word;
        logic [31:0] exp;
        wb_write(frame_pkg::REG_DL_CTRL, 32'h1);
        rom_req  = 1'b1;
        rom_addr = DL_BASE / 4 + 5;
        for (int i = 0; i < 8; i++) begin
            next_cycle();
            expect_eq("rom_ack", rom_ack, 0);
        end
        wb_write(frame_pkg::REG_DL_CTRL, 32'h0);
        expect_eq("rom_ack", rom_ack, 1);  // One cycle after downloading fell
        rom_finish(word);
        exp = {dl_bytes[23], dl_bytes[22], dl_bytes[21], dl_bytes[20]};
        expect_eq("rom_data", word, exp);
    endtask

    task automatic reset_gen();
        frame_pkg::frame_status_u st;
        int cnt;
        cnt = 0;
        while (game_rst !== 1'b0) begin
            if (cnt == TIMEOUT) begin
                $display("Timeout waiting for game_rst to fall after the download");
                abort_run();
            end
            next_cycle();
            cnt++;
        end
        rst_req = 1'b1;
        next_cycle();
        expect_eq("game_rst", game_rst, 1);
        next_cycle();
        rst_req = 1'b0;
        expect_hold();
        st.raw = '0;
        st.fields.flip = 1'b1;
        wb_write(frame_pkg::REG_STATUS, st.raw);
        expect_hold();
    endtask

    task automatic sound_run(input logic signed_mode, input logic [15:0] sample);
        frame_pkg::frame_status_u st;
        logic [15:0] u;
        longint      ones;
        longint      diff;
        st.raw = '0;
        st.fields.flip       = 1'b1;  // Unchanged, no game reset
        st.fields.snd_signed = signed_mode;
        wb_write(frame_pkg::REG_STATUS, st.raw);
        snd = sample;
        u = signed_mode ? (sample ^ 16'h8000) : sample;  // Offset binary
        ones = 0;
        for (int i = 0; i < 4096; i++) begin
            next_cycle();
            ones += AUDIO_L;
            expect_eq("AUDIO_R", AUDIO_R, AUDIO_L);
        end
        diff = ones * 65536 - longint'(u) * 4096;
        assert (diff >= -65536 && diff <= 65536) else begin
            $display("Fail AUDIO_L ones: got %h, expected %h", ones, (longint'(u) * 4096) >> 16);
            abort_run();
        end
    endtask

    task automatic sound_dac();
        sound_run(1'b0, 16'h3000);
        sound_run(1'b0, 16'h1234);
        sound_run(1'b1, 16'hE000);
    endtask

    initial begin
        rst      = 1'b1;
        rst_req  = 1'b0;
        snd      = '0;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        rom_req  = 1'b0;
        rom_addr = '0;
        lfsr     = 16'd59;
        repeat (4) @(posedge clk_sys);
        #1;
        rst = 1'b0;
        expect_eq("wb_ack", wb_ack, 0);
        expect_eq("downloading", downloading, 0);
        expect_eq("rom_ack", rom_ack, 0);
        expect_eq("rom_data_rdy", rom_data_rdy, 0);
        expect_eq("AUDIO_L", AUDIO_L, 0);
        expect_eq("game_rst", game_rst, 1);  // Still counting down from rst
        reg_access();
        input_decode();
        download_readback();
        read_while_loading();
        reset_gen();
        sound_dac();
        $display("Done: no errors");
        $finish;
    end

endmodule

// File: logic/frame_top.sv
// No PLLs, SPI, OSD or SDRAM here; clk_sys and a synchronous rst come from outside
`timescale 1ns/1ps

module frame_top (
    input  logic                         clk_sys,
    input  logic                         rst,
    input  logic                         rst_req,
    input  logic [frame_pkg::SND_W-1:0]  snd,
    // Host configuration port
    input  logic                         wb_cyc,
    input  logic                         wb_stb,
    input  logic                         wb_we,
    input  logic [frame_pkg::WB_AW-1:0]  wb_adr,
    input  logic [frame_pkg::WB_DW-1:0]  wb_dat_w,
    output logic [frame_pkg::WB_DW-1:0]  wb_dat_r,
    output logic                         wb_ack,
    // ROM access from the game
    input  logic                         rom_req,
    input  logic [frame_pkg::ROM_AW-1:0] rom_addr,
    output logic                         rom_ack,
    output logic [frame_pkg::ROM_DW-1:0] rom_data,
    output logic                         rom_data_rdy,
    output logic                         downloading,
    output logic                         game_rst,
    // Game inputs and controls
    output logic [frame_pkg::JOY_W-1:0]  game_joystick1,
    output logic [frame_pkg::JOY_W-1:0]  game_joystick2,
    output logic [1:0]                   game_coin,
    output logic [1:0]                   game_start,
    output logic                         game_pause,
    output logic                         game_service,
    output logic [3:0]                   gfx_en,
    // Sound
    output logic                         AUDIO_L,
    output logic                         AUDIO_R
);

    logic [frame_pkg::DL_AW-1:0] ioctl_addr;
    logic [7:0]                  ioctl_data;
    logic                        ioctl_wr;
    logic                        flip;
    logic                        snd_signed;

    assign AUDIO_R = AUDIO_L;  // Mono core

    frame_regs u_regs (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .wb_cyc         ( wb_cyc         ),
        .wb_stb         ( wb_stb         ),
        .wb_we          ( wb_we          ),
        .wb_adr         ( wb_adr         ),
        .wb_dat_w       ( wb_dat_w       ),
        .wb_dat_r       ( wb_dat_r       ),
        .wb_ack         ( wb_ack         ),
        .downloading    ( downloading    ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data     ( ioctl_data     ),
        .ioctl_wr       ( ioctl_wr       ),
        .flip           ( flip           ),
        .snd_signed     ( snd_signed     ),
        .game_joystick1 ( game_joystick1 ),
        .game_joystick2 ( game_joystick2 ),
        .game_coin      ( game_coin      ),
        .game_start     ( game_start     ),
        .game_pause     ( game_pause     ),
        .game_service   ( game_service   ),
        .gfx_en         ( gfx_en         )
    );

    frame_reset u_reset (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .rst_req        ( rst_req        ),
        .flip           ( flip           ),
        .downloading    ( downloading    ),
        .game_rst       ( game_rst       )
    );

    frame_rom_ctrl u_rom (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .downloading    ( downloading    ),
        .ioctl_addr     ( ioctl_addr     ),
        .ioctl_data     ( ioctl_data     ),
        .ioctl_wr       ( ioctl_wr       ),
        .rom_req        ( rom_req        ),
        .rom_addr       ( rom_addr       ),
        .rom_ack        ( rom_ack        ),
        .rom_data       ( rom_data       ),
        .rom_data_rdy   ( rom_data_rdy   )
    );

    frame_sd_dac u_dac (
        .clk_sys        ( clk_sys        ),
        .rst            ( rst            ),
        .snd_signed     ( snd_signed     ),
        .snd            ( snd            ),
        .snd_pwm        ( AUDIO_L        )
    );

endmodule

// File: logic/frame_sd_dac.sv
// First-order sigma-delta at clk_sys rate; needs an external RC low-pass on the pin
`timescale 1ns/1ps

module frame_sd_dac (
    input  logic                        clk_sys,
    input  logic                        rst,
    input  logic                        snd_signed,
    input  logic [frame_pkg::SND_W-1:0] snd,
    output logic                        snd_pwm
);

    logic [frame_pkg::SND_W-1:0] smp_u;
    logic [frame_pkg::SND_W-1:0] acc;

    // Offset binary: flipping the sign bit maps -32768 to 0
    assign smp_u = {snd[frame_pkg::SND_W-1] ^ snd_signed, snd[frame_pkg::SND_W-2:0]};

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            acc     <= '0;
            snd_pwm <= 1'b0;
        end else begin
            {snd_pwm, acc} <= {1'b0, acc} + {1'b0, smp_u};  // Carry is the output bit
        end
    end

endmodule

// File: logic/frame_rom_ctrl.sv
// On-chip 1024x32 buffer in place of SDRAM; one game read in flight, no reads while downloading
`timescale 1ns/1ps

module frame_rom_ctrl (
    input  logic                         clk_sys,
    input  logic                         rst,
    // Download side
    input  logic                         downloading,
    input  logic [frame_pkg::DL_AW-1:0]  ioctl_addr,
    input  logic [7:0]                   ioctl_data,
    input  logic                         ioctl_wr,
    // Game side
    input  logic                         rom_req,
    input  logic [frame_pkg::ROM_AW-1:0] rom_addr,
    output logic                         rom_ack,
    output logic [frame_pkg::ROM_DW-1:0] rom_data,
    output logic                         rom_data_rdy
);

    logic [3:0][7:0]              mem [frame_pkg::ROM_WORDS];
    logic [frame_pkg::ROM_AW-1:0] rd_addr;
    logic                         req_take;

    // Busy through ack and data cycles; held off while downloading
    assign req_take = rom_req & ~downloading & ~rom_ack & ~rom_data_rdy;

    // Byte lane 0 is the least significant
    always_ff @(posedge clk_sys) begin
        if (downloading && ioctl_wr) begin
            mem[ioctl_addr[frame_pkg::DL_AW-1:2]][ioctl_addr[1:0]] <= ioctl_data;
        end
    end

    // Read sequencer: accept, ack, data
    always_ff @(posedge clk_sys) begin
        if (rst) begin
            rom_ack      <= 1'b0;
            rom_data_rdy <= 1'b0;
        end else begin
            rom_ack      <= req_take;
            rom_data_rdy <= rom_ack;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (req_take) begin
            rd_addr <= rom_addr;  // Game may move the address after ack
        end
        if (rom_ack) begin
            rom_data <= mem[rd_addr];
        end
    end

    a_rdy_after_ack: assert property (@(posedge clk_sys) disable iff (rst)
        rom_data_rdy |-> $past(rom_ack));

endmodule

// File: logic/frame_reset.sv
// Game reset is held RST_HOLD cycles past the last cause; flip is assumed synchronous to clk_sys
`timescale 1ns/1ps

module frame_reset (
    input  logic clk_sys,
    input  logic rst,
    input  logic rst_req,
    input  logic flip,
    input  logic downloading,
    output logic game_rst
);

    logic                            flip_q;
    logic                            flip_chg;
    logic                            cause;
    logic [frame_pkg::RST_CNT_W-1:0] hold_cnt;

    assign flip_chg = flip ^ flip_q;  // Screen flip needs a fresh game start
    assign cause    = rst | downloading | rst_req | flip_chg;

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            flip_q   <= 1'b0;
            hold_cnt <= frame_pkg::RST_CNT_W'(frame_pkg::RST_HOLD);
        end else begin
            flip_q <= flip;
            if (cause) begin
                hold_cnt <= frame_pkg::RST_CNT_W'(frame_pkg::RST_HOLD);  // Reload
            end else if (hold_cnt != '0) begin
                hold_cnt <= hold_cnt - 1'b1;
            end
        end
    end

    assign game_rst = cause | (hold_cnt != '0);

    // Core never runs while the ROM is being rewritten
    a_rst_in_dl: assert property (@(posedge clk_sys) downloading |-> game_rst);

endmodule

// File: logic/frame_regs.sv
// Single-beat Wishbone classic only, no byte selects and no error or retry; one ack cycle per access
`timescale 1ns/1ps

module frame_regs (
    input  logic                        clk_sys,
    input  logic                        rst,
    // Host configuration port
    input  logic                        wb_cyc,
    input  logic                        wb_stb,
    input  logic                        wb_we,
    input  logic [frame_pkg::WB_AW-1:0] wb_adr,
    input  logic [frame_pkg::WB_DW-1:0] wb_dat_w,
    output logic [frame_pkg::WB_DW-1:0] wb_dat_r,
    output logic                        wb_ack,
    // Download stream
    output logic                        downloading,
    output logic [frame_pkg::DL_AW-1:0] ioctl_addr,
    output logic [7:0]                  ioctl_data,
    output logic                        ioctl_wr,
    // Status controls
    output logic                        flip,
    output logic                        snd_signed,
    // Game inputs
    output logic [frame_pkg::JOY_W-1:0] game_joystick1,
    output logic [frame_pkg::JOY_W-1:0] game_joystick2,
    output logic [1:0]                  game_coin,
    output logic [1:0]                  game_start,
    output logic                        game_pause,
    output logic                        game_service,
    output logic [3:0]                  gfx_en
);

    frame_pkg::frame_status_u    status_q;
    logic [frame_pkg::JOY_W-1:0] joy1_q;
    logic [frame_pkg::JOY_W-1:0] joy2_q;
    logic [frame_pkg::DL_AW-1:0] dl_addr_q;
    logic                        wb_access;
    logic                        wb_wr;
    logic                        dl_wr;
    logic                        in_inv;
    logic [frame_pkg::WB_DW-1:0] rd_mux;

    assign wb_access = wb_cyc & wb_stb & ~wb_ack;  // New beat only
    assign wb_wr     = wb_access & wb_we;
    assign dl_wr     = wb_wr & (wb_adr == frame_pkg::REG_DL_DATA);
    assign in_inv    = ~frame_pkg::GAME_INPUTS_ACTIVE_HIGH;

    // Read-back; download data and holes read as zero
    always_comb begin
        rd_mux = '0;
        case (wb_adr)
            frame_pkg::REG_STATUS:  rd_mux = status_q.raw;
            frame_pkg::REG_JOY1:    rd_mux[frame_pkg::JOY_W-1:0] = joy1_q;
            frame_pkg::REG_JOY2:    rd_mux[frame_pkg::JOY_W-1:0] = joy2_q;
            frame_pkg::REG_DL_CTRL: rd_mux[0] = downloading;
            frame_pkg::REG_DL_ADDR: rd_mux[frame_pkg::DL_AW-1:0] = dl_addr_q;
            default:                rd_mux = '0;
        endcase
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            wb_ack <= 1'b0;
        end else begin
            wb_ack <= wb_access;
        end
    end

    always_ff @(posedge clk_sys) begin
        if (wb_access) begin
            wb_dat_r <= rd_mux;  // Valid with wb_ack
        end
    end

    always_ff @(posedge clk_sys) begin
        if (rst) begin
            status_q.raw <= '0;
            joy1_q       <= '0;
            joy2_q       <= '0;
            downloading  <= 1'b0;
            dl_addr_q    <= '0;
            ioctl_wr     <= 1'b0;
        end else begin
            ioctl_wr <= dl_wr;
            if (wb_wr) begin
                case (wb_adr)
                    frame_pkg::REG_STATUS:  status_q.raw <= wb_dat_w;
                    frame_pkg::REG_JOY1:    joy1_q <= wb_dat_w[frame_pkg::JOY_W-1:0];
                    frame_pkg::REG_JOY2:    joy2_q <= wb_dat_w[frame_pkg::JOY_W-1:0];
                    frame_pkg::REG_DL_CTRL: downloading <= wb_dat_w[0];
                    frame_pkg::REG_DL_ADDR: dl_addr_q <= wb_dat_w[frame_pkg::DL_AW-1:0];
                    frame_pkg::REG_DL_DATA: dl_addr_q <= dl_addr_q + 1'b1;  // Auto-increment
                    default: ;
                endcase
            end
        end
    end

    // Byte strobe carries the address before the increment
    always_ff @(posedge clk_sys) begin
        if (dl_wr) begin
            ioctl_addr <= dl_addr_q;
            ioctl_data <= wb_dat_w[7:0];
        end
    end

    // Status decode
    assign flip         = status_q.fields.flip;
    assign snd_signed   = status_q.fields.snd_signed;
    assign game_pause   = status_q.fields.pause;
    assign game_service = status_q.fields.service;
    assign gfx_en       = status_q.fields.gfx_en;

    // Game input polarity, player 2 in the upper bit
    assign game_joystick1 = joy1_q ^ {frame_pkg::JOY_W{in_inv}};
    assign game_joystick2 = joy2_q ^ {frame_pkg::JOY_W{in_inv}};
    assign game_coin  = {joy2_q[frame_pkg::JOY_COIN], joy1_q[frame_pkg::JOY_COIN]} ^ {2{in_inv}};
    assign game_start = {joy2_q[frame_pkg::JOY_START], joy1_q[frame_pkg::JOY_START]}
                        ^ {2{in_inv}};

    // Host must drop stb or wait a cycle between beats
    a_ack_single: assert property (@(posedge clk_sys) disable iff (rst) wb_ack |=> !wb_ack);

endmodule

// File: logic/frame_pkg.sv
// Sizes are fixed at build time; host firmware must use the same register map and status bits
package frame_pkg;

    // Wishbone configuration port, word addresses
    localparam int WB_AW = 3;
    localparam int WB_DW = 32;

    localparam logic [WB_AW-1:0] REG_STATUS  = 3'd0;
    localparam logic [WB_AW-1:0] REG_JOY1    = 3'd1;
    localparam logic [WB_AW-1:0] REG_JOY2    = 3'd2;
    localparam logic [WB_AW-1:0] REG_DL_CTRL = 3'd3;  // Bit 0 is downloading
    localparam logic [WB_AW-1:0] REG_DL_ADDR = 3'd4;
    localparam logic [WB_AW-1:0] REG_DL_DATA = 3'd5;  // Write only, low byte

    // On-chip ROM buffer standing in for SDRAM
    localparam int ROM_AW    = 10;
    localparam int ROM_DW    = 32;
    localparam int ROM_WORDS = 1 << ROM_AW;
    localparam int DL_AW     = ROM_AW + 2;  // Byte address, little-endian lanes

    // Joystick word: 3..0 directions, 7..4 buttons
    localparam int JOY_W     = 10;
    localparam int JOY_COIN  = 8;
    localparam int JOY_START = 9;

    // Game inputs leave the framework inverted when 0
    localparam logic GAME_INPUTS_ACTIVE_HIGH = 1'b0;

    // Game reset hold after the last cause
    localparam int RST_HOLD  = 16;
    localparam int RST_CNT_W = $clog2(RST_HOLD + 1);

    localparam int SND_W = 16;

    // Core status word as set by the host
    typedef union packed {
        logic [31:0] raw;
        struct packed {
            logic [23:0] reserved;
            logic [3:0]  gfx_en;      // Layer enables for debug
            logic        snd_signed;  // Sound sample is two's complement
            logic        service;
            logic        pause;
            logic        flip;        // Bit 0
        } fields;
    } frame_status_u;

endpackage
